// File: list.f
+incdir+hdl
hdl/reuleaux_pkg.sv
hdl/draw_regs.sv
hdl/circle_clip.sv
hdl/reuleaux.sv
hdl/shape_top.sv
tb/reuleaux_props.sv
tb/tb_shape_top.sv

// File: run.sh
#!/bin/sh
# build and run the shape_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_shape_top -f list.f \
  --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test OK"; then
  exit 0
fi
exit 1

// File: tb/tb_shape_top.sv
`timescale 1ns/1ps
`include "reuleaux_defines.svh"

module tb_shape_top;
  import reuleaux_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_CASES  = 26;
  localparam int ARC_CYCLES = 5000;   // three arcs at diameter 255, with room to spare

  logic       clk;
  logic       rst_n;
  logic       wr_en;
  reg_addr_t  wr_addr;
  logic [7:0] wr_data;
  reg_addr_t  rd_addr;
  logic [7:0] rd_data;
  logic       start;
  logic       done;
  pixel_t     pix;
  logic       plot;

  pixel_t      exp_q[$];        // reference pixels still to be plotted
  int          mismatches;
  int          failures;
  int          pix_mismatches;
  int          pix_failures;
  int          checked;
  int          plotted;
  logic [31:0] lfsr;

  shape_top dut (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd_addr(rd_addr),
    .rd_data(rd_data),
    .start  (start),
    .done   (done),
    .pix    (pix),
    .plot   (plot)
  );

  bind reuleaux reuleaux_props u_props (
    .clk  (clk),
    .rst_n(rst_n),
    .start(start),
    .done (done),
    .plot (plot),
    .pix  (pix),
    .state(state)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [7:0] take_bits(int n);
    logic [7:0] v;
    int         i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[6:0], lfsr[0]};
    end
    return v;
  endfunction

  // one circle, walk order, kept only inside the window and on the screen
  function automatic void trace_arc(int ccx, int ccy, int rad, int x0, int x1, int y0,
                                    int y1, colour_t col);
    int x;
    int y;
    int err;
    int k;
    int a;
    int b;
    int px;
    int py;
    x   = rad;
    y   = 0;
    err = 1 - rad;
    while (y <= x) begin
      for (k = 0; k < 8; k++) begin
        a  = (k % 2 == 1) ? y : x;   // odd octants swap the axes
        b  = (k % 2 == 1) ? x : y;
        px = (k >= 2 && k <= 5) ? ccx - a : ccx + a;
        py = (k >= 4) ? ccy - b : ccy + b;
        if (px >= x0 && px <= x1 && py >= y0 && py <= y1 &&
            px >= 0 && px < `SCREEN_W && py >= 0 && py < `SCREEN_H) begin
          exp_q.push_back(pixel_t'{x: px[7:0], y: py[6:0], colour: col});
        end
      end
      y++;
      if (err > 0) begin
        x--;
        err += 2 * (y - x) + 1;
      end else begin
        err += 2 * y + 1;
      end
    end
  endfunction

  function automatic void build_expected(colour_t col, int cx0, int cy0, int d);
    int r;
    int t;
    int td;
    int ax;
    int ay;
    int bx;
    int by;
    int vx;
    int vy;
    exp_q.delete();
    r  = d / 2;
    t  = (r * `ROOT3_Q + (1 << (`ROOT3_FRAC - 1))) >> `ROOT3_FRAC;
    td = (d * `ROOT3_Q + (1 << (`ROOT3_FRAC - 1))) >> `ROOT3_FRAC;
    ax = cx0 + r;
    ay = cy0 + t;
    bx = cx0 - r;
    by = cy0 + t;
    vx = cx0;
    vy = cy0 - td;       // top vertex
    trace_arc(ax, ay, d, bx, vx, vy, by, col);
    trace_arc(bx, by, d, vx, ax, vy, ay, col);
    trace_arc(vx, vy, d, bx, ax, ay, `SCREEN_H - 1, col);
  endfunction

  task automatic report_counts();
    $display("errors: %0d mismatches, %0d other failures, %0d pixels checked",
             mismatches + pix_mismatches, failures + pix_failures, checked);
  endtask

  task automatic write_reg(reg_addr_t addr, logic [7:0] data);
    @(posedge clk);
    #5;
    wr_en   = 1'b1;
    wr_addr = addr;
    wr_data = data;
    @(posedge clk);
    #5;
    wr_en = 1'b0;
  endtask

  task automatic check_reg(reg_addr_t addr, logic [7:0] want);
    @(posedge clk);
    #5;
    rd_addr = addr;
    @(negedge clk);
    assert (rd_data == want) else begin
      mismatches++;
      $display("mismatch rd_data at address %0d: expected %h got %h", addr, want, rd_data);
    end
  endtask

  task automatic wait_done(int limit);
    int n;
    n = 0;
    while (!done && n < limit) begin
      @(negedge clk);
      n++;
    end
    assert (done) else begin
      failures++;
      $display("done did not rise within %0d cycles", limit);
    end
  endtask

  task automatic run_drawing(colour_t col, xpos_t cx, ypos_t cy, logic [7:0] d,
                             bit overwrite);
    int expected;
    int seen;
    write_reg(2'd0, 8'(col));
    write_reg(2'd1, cx);
    write_reg(2'd2, 8'(cy));
    write_reg(2'd3, d);
    build_expected(col, cx, cy, d);
    expected = exp_q.size();
    seen     = plotted;
    @(posedge clk);
    #5;
    start = 1'b1;
    if (overwrite) begin
      write_reg(2'd0, 8'(col + 3'd1));   // engine already holds its copy
      write_reg(2'd1, cx ^ 8'h15);
      write_reg(2'd3, d + 8'd9);
    end
    wait_done(ARC_CYCLES);
    assert (plotted - seen == expected) else begin
      mismatches++;
      $display("mismatch plot count: expected %h got %h", expected, plotted - seen);
    end
    repeat (3) begin
      @(negedge clk);
      assert (done) else begin
        failures++;
        $display("done dropped while start was still held");
      end
    end
    @(posedge clk);
    #5;
    start = 1'b0;
    @(negedge clk);
    @(negedge clk);
    assert (!done) else begin
      failures++;
      $display("done still high one cycle after start fell");
    end
  endtask

  // every plot is matched against the next reference pixel
  always @(negedge clk) begin
    pixel_t want;
    if (rst_n && plot) begin
      plotted++;
      assert (pix.x < `SCREEN_W && pix.y < `SCREEN_H) else begin
        pix_failures++;
        $display("pixel plotted off the screen at x %0d y %0d", pix.x, pix.y);
      end
      assert (exp_q.size() > 0) else begin
        pix_failures++;
        $display("plot raised with no pixel left in the reference sequence");
      end
      if (exp_q.size() > 0) begin
        want = exp_q.pop_front();
        checked++;
        assert (pix.x == want.x) else begin
          pix_mismatches++;
          $display("mismatch pix.x: expected %h got %h", want.x, pix.x);
        end
        assert (pix.y == want.y) else begin
          pix_mismatches++;
          $display("mismatch pix.y: expected %h got %h", want.y, pix.y);
        end
        assert (pix.colour == want.colour) else begin
          pix_mismatches++;
          $display("mismatch pix.colour: expected %h got %h", want.colour, pix.colour);
        end
      end
    end
  end

  initial begin
    #(CLK_PERIOD * (NUM_CASES * ARC_CYCLES + 2000));
    $display("watchdog expired before the tests completed");
    report_counts();
    $display("Test FAILED");
    $finish;
  end

  initial begin
    int         i;
    colour_t    col;
    xpos_t      rx;
    ypos_t      ry;
    logic [7:0] rdia;
    wr_en          = 1'b0;
    wr_addr        = '0;
    wr_data        = '0;
    rd_addr        = '0;
    start          = 1'b0;
    rst_n          = 1'b0;
    mismatches     = 0;
    failures       = 0;
    pix_mismatches = 0;
    pix_failures   = 0;
    checked        = 0;
    plotted        = 0;
    lfsr           = 32'h64ae;
    repeat (2) @(posedge clk);
    #5;
    rst_n = 1'b1;

    // register block, reset values then truncation
    check_reg(2'd0, 8'h00);
    check_reg(2'd1, 8'h00);
    check_reg(2'd2, 8'h00);
    check_reg(2'd3, 8'h00);
    write_reg(2'd0, 8'hfd);
    write_reg(2'd1, 8'ha7);
    write_reg(2'd2, 8'hf3);
    write_reg(2'd3, 8'h9c);
    check_reg(2'd0, 8'h05);
    check_reg(2'd1, 8'ha7);
    check_reg(2'd2, 8'h73);
    check_reg(2'd3, 8'h9c);

    run_drawing(3'd5, 8'd80, 7'd60, 8'd40, 1'b0);     // centred
    run_drawing(3'd2, 8'd6, 7'd4, 8'd200, 1'b0);      // top left corner
    run_drawing(3'd3, 8'd155, 7'd116, 8'd180, 1'b0);  // bottom right corner
    run_drawing(3'd6, 8'd70, 7'd50, 8'd60, 1'b1);     // writes during the drawing

    for (i = 0; i < 20; i++) begin
      col  = colour_t'(take_bits(3));
      rx   = xpos_t'(take_bits(8) % 160);
      ry   = ypos_t'(take_bits(7) % 120);
      rdia = take_bits(8);
      run_drawing(col, rx, ry, rdia, 1'b0);
    end

    run_drawing(3'd7, 8'd40, 7'd30, 8'd0, 1'b0);
    run_drawing(3'd1, 8'd120, 7'd90, 8'd1, 1'b0);

    repeat (2) @(posedge clk);
    report_counts();
    if (mismatches + pix_mismatches == 0 && failures + pix_failures == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: tb/reuleaux_props.sv
`timescale 1ns/1ps
`include "reuleaux_defines.svh"

module reuleaux_props (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     start,
  input logic                     done,
  input logic                     plot,
  input reuleaux_pkg::pixel_t     pix,
  input reuleaux_pkg::eng_state_t state
);
  import reuleaux_pkg::*;

  // nothing plotted while waiting for start
  idle_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    state == IDLE |-> !plot)
    else $error("plot high while the engine is idle");

  done_needs_start: assert property (@(posedge clk) disable iff (!rst_n)
    done |-> $past(start))
    else $error("done high without start in the previous cycle");

  // released one cycle after start goes away
  done_release: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(start) |=> !done)
    else $error("done still high after start fell");

  pix_on_screen: assert property (@(posedge clk) disable iff (!rst_n)
    plot |-> (pix.x < `SCREEN_W && pix.y < `SCREEN_H))
    else $error("plotted pixel lies outside the frame");

endmodule

// File: hdl/shape_top.sv
`timescale 1ns/1ps

module shape_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    wr_en,
  input  reuleaux_pkg::reg_addr_t wr_addr,
  input  logic [7:0]              wr_data,
  input  reuleaux_pkg::reg_addr_t rd_addr,
  output logic [7:0]              rd_data,
  input  logic                    start,
  output logic                    done,
  output reuleaux_pkg::pixel_t    pix,
  output logic                    plot
);
  import reuleaux_pkg::*;

  draw_cfg_t cfg;   // live register contents

  draw_regs u_regs (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd_addr(rd_addr),
    .rd_data(rd_data),
    .cfg    (cfg)
  );

  reuleaux u_engine (
    .clk  (clk),
    .rst_n(rst_n),
    .start(start),
    .cfg  (cfg),
    .done (done),
    .pix  (pix),
    .plot (plot)
  );

endmodule

// File: hdl/reuleaux.sv
`timescale 1ns/1ps
`include "reuleaux_defines.svh"

module reuleaux (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,
  input  reuleaux_pkg::draw_cfg_t cfg,
  output logic                    done,
  output reuleaux_pkg::pixel_t    pix,
  output logic                    plot
);
  import reuleaux_pkg::*;

  eng_state_t  state;
  draw_cfg_t   cfg_q;          // copy taken when leaving IDLE
  logic [6:0]  r;
  logic [18:0] t_prod;
  logic [18:0] td_prod;
  logic [7:0]  t_q;
  logic [7:0]  td_q;
  coord_t      cen_x;
  coord_t      cen_y;
  coord_t      r_c;
  coord_t      t_c;
  coord_t      td_c;
  coord_t      ax;             // vertices, each one an arc centre
  coord_t      ay;
  coord_t      bx;
  coord_t      by;
  coord_t      cx;
  coord_t      cy;
  coord_t      arc_cx;
  coord_t      arc_cy;
  clip_win_t   win;
  logic        arc_start;
  logic        arc_done;

  assign r = cfg_q.diameter[7:1];

  // offsets r/sqrt(3) and d/sqrt(3), half an lsb added before truncation
  assign t_prod  = 19'(r) * 19'(`ROOT3_Q) + 19'(1 << (`ROOT3_FRAC - 1));
  assign td_prod = 19'(cfg_q.diameter) * 19'(`ROOT3_Q) + 19'(1 << (`ROOT3_FRAC - 1));

  assign cen_x = {2'b00, cfg_q.centre_x};
  assign cen_y = {3'b000, cfg_q.centre_y};
  assign r_c   = {3'b000, r};
  assign t_c   = {2'b00, t_q};
  assign td_c  = {2'b00, td_q};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else if (!start) begin
      state <= IDLE;   // finished or abandoned
    end else begin
      case (state)
        IDLE:  state <= LATCH;
        LATCH: state <= CALC;
        CALC:  state <= ARC_A;
        ARC_A: begin
          if (arc_done) state <= ARC_B;
        end
        ARC_B: begin
          if (arc_done) state <= ARC_C;
        end
        ARC_C: begin
          if (arc_done) state <= DONE;
        end
        DONE:    state <= DONE;
        default: state <= IDLE;
      endcase
    end
  end

  // datapath, one stage per state
  always_ff @(posedge clk) begin
    if (state == IDLE && start) begin
      cfg_q <= cfg;
    end
    if (state == LATCH) begin
      t_q  <= t_prod[`ROOT3_FRAC +: 8];
      td_q <= td_prod[`ROOT3_FRAC +: 8];
    end
    if (state == CALC) begin
      ax <= cen_x + r_c;
      ay <= cen_y + t_c;
      bx <= cen_x - r_c;
      by <= cen_y + t_c;
      cx <= cen_x;
      cy <= cen_y - td_c;    // top vertex, may sit above the screen
    end
  end

  // centre and window for the arc being traced
  always_comb begin
    arc_cx    = cx;
    arc_cy    = cy;
    win.min_x = bx;
    win.max_x = ax;
    win.min_y = ay;
    win.max_y = coord_t'(`SCREEN_H - 1);
    case (state)
      ARC_A: begin
        arc_cx    = ax;
        arc_cy    = ay;
        win.min_x = bx;
        win.max_x = cx;
        win.min_y = cy;
        win.max_y = by;
      end
      ARC_B: begin
        arc_cx    = bx;
        arc_cy    = by;
        win.min_x = cx;
        win.max_x = ax;
        win.min_y = cy;
        win.max_y = ay;
      end
      default: begin
      end
    endcase
  end

  // low for one cycle once an arc reports done, which restarts the walker
  assign arc_start = (state == ARC_A || state == ARC_B || state == ARC_C) && !arc_done;
  assign done      = (state == DONE);

  circle_clip u_circle (
    .clk      (clk),
    .rst_n    (rst_n),
    .arc_start(arc_start),
    .centre_x (arc_cx),
    .centre_y (arc_cy),
    .radius   (cfg_q.diameter),
    .win      (win),
    .colour   (cfg_q.colour),
    .arc_done (arc_done),
    .pix      (pix),
    .plot     (plot)
  );

endmodule

// File: hdl/circle_clip.sv
`timescale 1ns/1ps
`include "reuleaux_defines.svh"

module circle_clip (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    arc_start,
  input  reuleaux_pkg::coord_t    centre_x,
  input  reuleaux_pkg::coord_t    centre_y,
  input  logic [7:0]              radius,
  input  reuleaux_pkg::clip_win_t win,
  input  reuleaux_pkg::colour_t   colour,
  output logic                    arc_done,
  output reuleaux_pkg::pixel_t    pix,
  output logic                    plot
);
  import reuleaux_pkg::*;

  coord_t             ox;        // step offsets, x shrinks and y grows
  coord_t             oy;
  coord_t             ox_n;
  coord_t             oy_n;
  coord_t             r_c;
  logic signed [11:0] crit;      // midpoint error term
  logic signed [11:0] crit_n;
  oct_t               oct;
  logic               finished;
  logic signed [11:0] a;
  logic signed [11:0] b;
  logic signed [11:0] px;        // candidate, wide enough for far off-screen points
  logic signed [11:0] py;
  logic               in_win;
  logic               on_scr;

  function automatic logic signed [11:0] wide(coord_t v);
    return {{2{v[9]}}, v};
  endfunction

  assign r_c      = {2'b00, radius};
  assign finished = (oy > ox);

  // next midpoint step
  always_comb begin
    oy_n   = oy + 10'sd1;
    ox_n   = ox;
    crit_n = crit + 2 * wide(oy_n) + 12'sd1;
    if (crit > 0) begin
      ox_n   = ox - 10'sd1;   // midpoint outside, step inwards
      crit_n = crit + 2 * (wide(oy_n) - wide(ox_n)) + 12'sd1;
    end
  end

  // octant order
  // 0 (+x,+y) 1 (+y,+x) 2 (-x,+y) 3 (-y,+x)
  // 4 (-x,-y) 5 (-y,-x) 6 (+x,-y) 7 (+y,-x)
  always_comb begin
    a  = oct[0] ? wide(oy) : wide(ox);
    b  = oct[0] ? wide(ox) : wide(oy);
    px = wide(centre_x) + ((oct[2] ^ oct[1]) ? -a : a);
    py = wide(centre_y) + (oct[2] ? -b : b);
  end

  assign in_win = (px >= wide(win.min_x)) && (px <= wide(win.max_x)) &&
                  (py >= wide(win.min_y)) && (py <= wide(win.max_y));
  assign on_scr = (px >= 0) && (px < `SCREEN_W) && (py >= 0) && (py < `SCREEN_H);

  // walker state, held at (radius, 0) while arc_start is low
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ox       <= '0;
      oy       <= '0;
      crit     <= '0;
      oct      <= '0;
      arc_done <= 1'b0;
    end else if (!arc_start) begin
      ox       <= r_c;
      oy       <= '0;
      crit     <= 12'sd1 - wide(r_c);
      oct      <= '0;
      arc_done <= 1'b0;
    end else if (finished) begin
      arc_done <= 1'b1;   // stays up until arc_start drops
    end else begin
      oct <= oct + 3'd1;
      if (oct == 3'd7) begin
        ox   <= ox_n;
        oy   <= oy_n;
        crit <= crit_n;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      plot <= 1'b0;
    end else begin
      plot <= arc_start && !finished && in_win && on_scr;
    end
  end

  // point registered alongside its plot decision
  always_ff @(posedge clk) begin
    pix.x      <= px[7:0];
    pix.y      <= py[6:0];
    pix.colour <= colour;
  end

endmodule

// File: hdl/draw_regs.sv
`timescale 1ns/1ps

module draw_regs (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    wr_en,
  input  reuleaux_pkg::reg_addr_t wr_addr,
  input  logic [7:0]              wr_data,
  input  reuleaux_pkg::reg_addr_t rd_addr,
  output logic [7:0]              rd_data,
  output reuleaux_pkg::draw_cfg_t cfg
);
  import reuleaux_pkg::*;

  // host writes, one field per address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg <= '0;
    end else if (wr_en) begin
      case (wr_addr)
        2'd0: begin
          cfg.colour <= colour_t'(wr_data);     // upper bits dropped
        end
        2'd1: begin
          cfg.centre_x <= xpos_t'(wr_data);
        end
        2'd2: begin
          cfg.centre_y <= ypos_t'(wr_data);     // 7 bits kept
        end
        default: begin
          cfg.diameter <= wr_data;
        end
      endcase
    end
  end

  // readback follows rd_addr in the same cycle
  always_comb begin
    case (rd_addr)
      2'd0: begin
        rd_data = 8'(cfg.colour);
      end
      2'd1: begin
        rd_data = 8'(cfg.centre_x);
      end
      2'd2: begin
        rd_data = 8'(cfg.centre_y);
      end
      default: begin
        rd_data = cfg.diameter;
      end
    endcase
  end

endmodule

// File: hdl/reuleaux_pkg.sv
package reuleaux_pkg;

  typedef logic [2:0] colour_t;          // 3-bit rgb
  typedef logic [7:0] xpos_t;            // 0..159
  typedef logic [6:0] ypos_t;            // 0..119
  typedef logic signed [9:0] coord_t;    // working coordinate, may leave the screen
  typedef logic [2:0] oct_t;             // octant index of the circle walker
  typedef logic [1:0] reg_addr_t;        // 0 colour, 1 centre_x, 2 centre_y, 3 diameter

  typedef struct packed {
    colour_t    colour;
    xpos_t      centre_x;
    ypos_t      centre_y;
    logic [7:0] diameter;
  } draw_cfg_t;

  // inclusive bounds
  typedef struct packed {
    coord_t min_x;
    coord_t max_x;
    coord_t min_y;
    coord_t max_y;
  } clip_win_t;

  typedef struct packed {
    xpos_t   x;
    ypos_t   y;
    colour_t colour;
  } pixel_t;

  typedef enum logic [2:0] {
    IDLE,
    LATCH,   // take a copy of the configuration
    CALC,    // vertices from centre, r, t and td
    ARC_A,
    ARC_B,
    ARC_C,
    DONE
  } eng_state_t;

endpackage

// File: hdl/reuleaux_defines.svh
`ifndef REULEAUX_DEFINES_SVH
`define REULEAUX_DEFINES_SVH

// frame buffer geometry, fixed by the external memory
`define SCREEN_W 160
`define SCREEN_H 120

// 1/sqrt(3) in fixed point, 1182 / 2048 is about 0.5771
`define ROOT3_Q    1182
`define ROOT3_FRAC 11

`endif
